// ==== logic/mixer_config.svh ====
/*
 * widths and table depths for the colour mixer
 * included by the package and by every RTL module that sizes ports
 */
`ifndef MIXER_CONFIG_SVH
`define MIXER_CONFIG_SVH

// bits per colour channel, three channels per palette entry
`define COLOR_W 4

// palette address width
// top bit selects the pause bank for objects
`define PAL_AW 9

// priority table address width
// {char opaque, obj opaque, obj hint[1:0], scr1 opaque}
`define PRIO_AW 5

// priority table entry width
// bits 1:0 layer select, bits 3:2 high palette bits
`define PRIO_DW 4

`endif

// ==== logic/mixer_pkg.sv ====
/*
 * shared types for the colour mixer
 * modules take these with a wildcard import in their header
 */
`include "mixer_config.svh"

package mixer_pkg;

    // layer pixels as delivered by the tile and sprite generators
    typedef logic [3:0] char_pxl_t;  // all ones is transparent
    typedef logic [5:0] scr_pxl_t;   // low nibble all ones is transparent
    typedef logic [7:0] obj_pxl_t;   // 7:6 priority hint, low nibble transparent code

    // priority table entry
    typedef logic [`PRIO_DW-1:0] prio_sel_t;

    // palette side
    typedef logic [`PAL_AW-1:0] pal_addr_t;
    typedef logic [3*`COLOR_W-1:0] rgb_t;  // {red, green, blue}

    // host write address, same reach as the palette
    typedef logic [`PAL_AW-1:0] host_addr_t;

    // host palette write buffer
    typedef enum logic {
        IDLE,     // nothing buffered
        PENDING   // write held until the store grants it
    } writer_state_t;

endpackage

// ==== logic/palette_bus_if.sv ====
/*
 * palette memory bus, two masters and one store
 * the pixel reader owns cen cycles, the host writer gets the gaps
 */
`timescale 1ns/10ps

interface palette_bus_if import mixer_pkg::*; (
    input logic clk
);

    pal_addr_t  rd_addr;   // from the pixel pipeline
    rgb_t       rd_data;   // registered colour back
    pal_addr_t  wr_addr;
    rgb_t       wr_data;
    logic       wr_req;    // held until granted
    logic       wr_gnt;    // combinational, write lands on this edge

    modport reader (input clk, output rd_addr, input rd_data);
    modport writer (input clk, output wr_addr, output wr_data, output wr_req, input wr_gnt);
    modport store  (input clk, input rd_addr, output rd_data,
                    input wr_addr, input wr_data, input wr_req, output wr_gnt);

    // a request may only be withdrawn by its own grant
    a_req_held : assert property (@(posedge clk) wr_req && !wr_gnt |=> wr_req)
        else $error("palette write request dropped before grant");

endinterface

// ==== logic/layer_priority.sv ====
/*
 * layer selection for the colour mixer
 * stage 1 latches the four layer pixels with the priority table lookup,
 * stage 2 muxes the winning colour and registers the palette address
 * both stages advance on cen, the host writes the table on any clk
 */
`include "mixer_config.svh"
`timescale 1ns/10ps

module layer_priority import mixer_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                cen,
    input  char_pxl_t           char_pxl,
    input  scr_pxl_t            scr1_pxl,
    input  scr_pxl_t            scr2_pxl,
    input  obj_pxl_t            obj_pxl,
    input  logic [3:0]          gfx_en,     // 0 char, 1 scr1, 2 scr2, 3 obj
    input  logic                lvbl,
    input  logic                lhbl,
    input  logic                pause,
    input  logic                prio_we,
    input  logic [`PRIO_AW-1:0] prio_addr,
    input  logic [`PRIO_DW-1:0] prio_data,
    palette_bus_if.reader       pal
);

    // layer codes in prio entry bits 1:0
    localparam logic [1:0] LAYER_SCR2 = 2'd0;
    localparam logic [1:0] LAYER_SCR1 = 2'd1;
    localparam logic [1:0] LAYER_OBJ  = 2'd2;
    localparam logic [1:0] LAYER_CHAR = 2'd3;

    prio_sel_t              prio_mem [0:2**`PRIO_AW-1];  // loaded by host, no init

    logic                   char_opaque;
    logic                   scr1_opaque;
    logic                   obj_opaque;
    scr_pxl_t               scr2_gated;
    logic [`PRIO_AW-1:0]    prio_idx;

    // stage 1
    char_pxl_t              char_q;
    scr_pxl_t               scr1_q;
    scr_pxl_t               scr2_q;
    obj_pxl_t               obj_q;
    prio_sel_t              sel_q;

    // stage 2
    logic [5:0]             color_mux;
    logic                   obj_bank;
    pal_addr_t              pal_addr_q;

    // opaque = enabled and not the all ones code
    assign char_opaque = gfx_en[0] & ~&char_pxl;
    assign scr1_opaque = gfx_en[1] & ~&scr1_pxl[3:0];
    assign obj_opaque  = gfx_en[3] & ~&obj_pxl[3:0];

    // scroll 2 is the backmost plane and never enters the lookup
    // when disabled it shows as its transparent code
    assign scr2_gated = gfx_en[2] ? scr2_pxl : '1;

    assign prio_idx = {char_opaque, obj_opaque, obj_pxl[7:6], scr1_opaque};

    // host table write, lands on the strobe edge
    always_ff @(posedge clk) begin
        if (prio_we) begin
            prio_mem[prio_addr] <= prio_data;
        end
    end

    // pixels wait one cen so the lookup result lines up with them
    always_ff @(posedge clk) begin
        if (cen) begin
            char_q <= char_pxl;
            scr1_q <= scr1_pxl;
            scr2_q <= scr2_gated;
            obj_q  <= obj_pxl;
            sel_q  <= prio_mem[prio_idx];
        end
    end

    always_comb begin
        case (sel_q[1:0])
            LAYER_SCR2: color_mux = scr2_q;
            LAYER_SCR1: color_mux = scr1_q;
            LAYER_OBJ:  color_mux = obj_q[5:0];
            LAYER_CHAR: color_mux = {2'b00, char_q};  // chars only have 16 colours
        endcase
    end

    assign obj_bank = pause && (sel_q[1:0] == LAYER_OBJ);  // upper half during pause

    always_ff @(posedge clk) begin
        if (reset) begin
            pal_addr_q <= '0;
        end else if (cen) begin
            if (lvbl && lhbl) begin
                pal_addr_q <= {obj_bank, sel_q[3:2], color_mux};
            end else begin
                pal_addr_q <= '0;  // blanking reads entry 0
            end
        end
    end

    assign pal.rd_addr = pal_addr_q;

    // the store must never see an unknown address once reset lets go
    // tables come up unloaded, so the host fills them while blanked
    a_addr_known : assert property (@(posedge clk) disable iff (reset)
        !$isunknown(pal.rd_addr))
        else $error("palette address unknown after reset");

endmodule

// ==== logic/palette_writer.sv ====
/*
 * host write decoder
 * priority table writes pass straight through, palette writes are
 * buffered and held on the palette bus until the store grants them
 */
`include "mixer_config.svh"
`timescale 1ns/10ps

module palette_writer import mixer_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                host_we,      // one clk strobe
    input  logic                host_target,  // 0 palette, 1 priority table
    input  host_addr_t          host_addr,
    input  rgb_t                host_data,
    output logic                host_busy,
    output logic                prio_we,
    output logic [`PRIO_AW-1:0] prio_addr,
    output logic [`PRIO_DW-1:0] prio_data,
    palette_bus_if.writer       pal
);

    writer_state_t  state_q;
    pal_addr_t      addr_q;   // buffered palette write
    rgb_t           data_q;

    // table writes never wait
    assign prio_we   = host_we && host_target;
    assign prio_addr = host_addr[`PRIO_AW-1:0];
    assign prio_data = host_data[`PRIO_DW-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    if (host_we && !host_target) state_q <= PENDING;
                PENDING: if (pal.wr_gnt) state_q <= IDLE;  // written on this edge
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (host_we && !host_target) begin
            addr_q <= host_addr;
            data_q <= host_data;
        end
    end

    assign pal.wr_req  = (state_q == PENDING);
    assign pal.wr_addr = addr_q;
    assign pal.wr_data = data_q;
    assign host_busy   = (state_q == PENDING);

    // a new strobe would overwrite the buffer before it reached memory
    a_no_we_busy : assert property (@(posedge clk) disable iff (reset)
        host_we |-> state_q != PENDING)
        else $error("host write strobe while palette write pending");

endmodule

// ==== logic/palette_store.sv ====
/*
 * shared palette memory
 * the pixel reader owns every cen cycle and gets a registered colour,
 * the host writer is granted the clk cycles between cen strobes
 * with cen low at least every other clk a write waits two clk at most
 */
`include "mixer_config.svh"
`timescale 1ns/10ps

module palette_store import mixer_pkg::*; (
    input  logic            clk,
    input  logic            cen,  // pixel strobe, reader priority
    palette_bus_if.store    pal
);

    localparam int DEPTH = 2**`PAL_AW;

    rgb_t   mem [0:DEPTH-1];  // lower half normal, upper half pause objects
    rgb_t   rd_q;
    logic   wr_grant;
    logic   rd_grant;

    // fixed priority, reader first
    assign rd_grant = cen;
    assign wr_grant = pal.wr_req && !rd_grant;

    assign pal.wr_gnt = wr_grant;

    // write side
    always_ff @(posedge clk) begin
        if (wr_grant) begin
            mem[pal.wr_addr] <= pal.wr_data;
        end
    end

    // read side, colour holds between cen strobes
    always_ff @(posedge clk) begin
        if (rd_grant) begin
            rd_q <= mem[pal.rd_addr];
        end
    end

    assign pal.rd_data = rd_q;

    // a grant only ever falls in a reader gap, and the writer lets go right after
    a_gnt_gap : assert property (@(posedge clk) pal.wr_gnt |-> !cen ##1 !pal.wr_req)
        else $error("palette grant overlaps cen or request not released");

endmodule

// ==== logic/pixel_mixer.sv ====
/*
 * colour mixer top level
 * four layer pixels in, 4-bit red green blue out two cen strobes later
 * the host loads the priority table and palette through host_we
 */
`include "mixer_config.svh"
`timescale 1ns/10ps

module pixel_mixer import mixer_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                cen,
    input  char_pxl_t           char_pxl,
    input  scr_pxl_t            scr1_pxl,
    input  scr_pxl_t            scr2_pxl,
    input  obj_pxl_t            obj_pxl,
    input  logic [3:0]          gfx_en,
    input  logic                lvbl,
    input  logic                lhbl,
    input  logic                pause,
    input  logic                host_we,
    input  logic                host_target,
    input  host_addr_t          host_addr,
    input  rgb_t                host_data,
    output logic [`COLOR_W-1:0] red,
    output logic [`COLOR_W-1:0] green,
    output logic [`COLOR_W-1:0] blue,
    output logic                host_busy
);

    logic                   prio_we;
    logic [`PRIO_AW-1:0]    prio_addr;
    logic [`PRIO_DW-1:0]    prio_data;
    logic                   out_en;  // first cen after reset loads a real colour

    palette_bus_if u_pal_bus (.clk(clk));

    layer_priority u_layer_priority (
        .clk       (clk),
        .reset     (reset),
        .cen       (cen),
        .char_pxl  (char_pxl),
        .scr1_pxl  (scr1_pxl),
        .scr2_pxl  (scr2_pxl),
        .obj_pxl   (obj_pxl),
        .gfx_en    (gfx_en),
        .lvbl      (lvbl),
        .lhbl      (lhbl),
        .pause     (pause),
        .prio_we   (prio_we),
        .prio_addr (prio_addr),
        .prio_data (prio_data),
        .pal       (u_pal_bus.reader)
    );

    palette_writer u_palette_writer (
        .clk         (clk),
        .reset       (reset),
        .host_we     (host_we),
        .host_target (host_target),
        .host_addr   (host_addr),
        .host_data   (host_data),
        .host_busy   (host_busy),
        .prio_we     (prio_we),
        .prio_addr   (prio_addr),
        .prio_data   (prio_data),
        .pal         (u_pal_bus.writer)
    );

    palette_store u_palette_store (
        .clk (clk),
        .cen (cen),
        .pal (u_pal_bus.store)
    );

    // keeps the stale palette register off the pins until it reloads
    always_ff @(posedge clk) begin
        if (reset) begin
            out_en <= 1'b0;
        end else if (cen) begin
            out_en <= 1'b1;
        end
    end

    assign red   = out_en ? u_pal_bus.rd_data[3*`COLOR_W-1:2*`COLOR_W] : '0;
    assign green = out_en ? u_pal_bus.rd_data[2*`COLOR_W-1:`COLOR_W]   : '0;
    assign blue  = out_en ? u_pal_bus.rd_data[`COLOR_W-1:0]            : '0;

endmodule

// ==== bench/mixer_tb.sv ====
/*
 * testbench for the colour mixer
 * loads palette and priority table over the host port, drives random layer
 * pixels on cen and checks red green blue against a bench model
 * one line per test, counts and verdict at the end
 */
`include "mixer_config.svh"
`timescale 1ns/10ps

module mixer_tb import mixer_pkg::*; ();

    localparam int N_PIXELS     = 200;
    localparam int N_WRITES     = 16;
    localparam int LOAD_BUDGET  = 512 * 6;                   // up to 5 clk per palette write
    localparam int PATH_BUDGET  = 4 * (40 + 32 * 4 + 20);     // table, pixels, drain per layer
    localparam int RAND_BUDGET  = 40 + N_PIXELS * 4 + 20;
    localparam int WRITE_BUDGET = N_WRITES * (4 + 6 + 40 + 3 * 4 + 20);
    localparam int CYCLE_LIMIT  = 2 * (16 + LOAD_BUDGET + PATH_BUDGET + 4 * RAND_BUDGET
                                       + WRITE_BUDGET);

    logic               clk;
    logic               reset;
    logic               cen;
    char_pxl_t          char_pxl;
    scr_pxl_t           scr1_pxl;
    scr_pxl_t           scr2_pxl;
    obj_pxl_t           obj_pxl;
    logic [3:0]         gfx_en;
    logic               lvbl;
    logic               lhbl;
    logic               pause;
    logic               host_we;
    logic               host_target;
    host_addr_t         host_addr;
    rgb_t               host_data;
    logic [`COLOR_W-1:0] red;
    logic [`COLOR_W-1:0] green;
    logic [`COLOR_W-1:0] blue;
    logic               host_busy;

    rgb_t       pal_model [0:2**`PAL_AW-1];   // bench copy of every write issued
    prio_sel_t  prio_model [0:2**`PRIO_AW-1];

    logic [1:0] cen_cnt;
    logic       checking;   // pixels sampled while set are compared
    int         cycle_count;
    int         err_count;
    int         check_count;
    int         test_count;
    int         test_fails;
    int         errs_before;
    int         seed_val;
    int         i;
    host_addr_t wr_addr;
    rgb_t       wr_data;

    // compare pipeline, one pixel set waiting for its blanking and pause
    char_pxl_t  s1_char;
    scr_pxl_t   s1_scr1;
    scr_pxl_t   s1_scr2;
    obj_pxl_t   s1_obj;
    logic [3:0] s1_en;
    bit         s1_valid;
    rgb_t       exp_q [$];
    bit         valid_q [$];
    rgb_t       pend_exp;
    bit         pend_valid;
    bit         have_pend;

    pixel_mixer u_pixel_mixer (
        .clk         (clk),
        .reset       (reset),
        .cen         (cen),
        .char_pxl    (char_pxl),
        .scr1_pxl    (scr1_pxl),
        .scr2_pxl    (scr2_pxl),
        .obj_pxl     (obj_pxl),
        .gfx_en      (gfx_en),
        .lvbl        (lvbl),
        .lhbl        (lhbl),
        .pause       (pause),
        .host_we     (host_we),
        .host_target (host_target),
        .host_addr   (host_addr),
        .host_data   (host_data),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .host_busy   (host_busy)
    );

    always #4 clk = ~clk;  // 8 ns

    // cen one clk in four
    always @(posedge clk) begin
        cen_cnt <= cen_cnt + 2'd1;
        cen     <= (cen_cnt == 2'd2);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout, run stopped after %0d clk cycles", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // expected colour of one pixel set, blanking and pause as seen a cen later
    function automatic rgb_t expected_rgb(input char_pxl_t c, input scr_pxl_t s1,
                                          input scr_pxl_t s2, input obj_pxl_t o,
                                          input logic [3:0] en, input logic vb,
                                          input logic hb, input logic pz);
        logic       c_op;
        logic       s1_op;
        logic       o_op;
        prio_sel_t  sel;
        logic [5:0] color;
        pal_addr_t  addr;
        c_op  = en[0] && (c != 4'hf);
        s1_op = en[1] && (s1[3:0] != 4'hf);
        o_op  = en[3] && (o[3:0] != 4'hf);
        sel   = prio_model[{c_op, o_op, o[7:6], s1_op}];
        case (sel[1:0])
            2'd0:    color = en[2] ? s2 : 6'h3f;  // disabled scroll 2 reads as transparent
            2'd1:    color = s1;
            2'd2:    color = o[5:0];
            default: color = {2'b00, c};
        endcase
        if (vb && hb) begin
            addr = {pz && (sel[1:0] == 2'd2), sel[3:2], color};
        end else begin
            addr = '0;
        end
        return pal_model[addr];
    endfunction

    task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
        if (actual !== expected) begin
            err_count++;
            $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_busy(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            err_count++;
            $display("ERR %0t %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    // pixel n lands after cen n+2, checked at the negedge after that
    always begin
        @(posedge clk);
        if (cen) begin
            have_pend = (exp_q.size() > 0);
            if (have_pend) begin
                pend_exp   = exp_q.pop_front();
                pend_valid = valid_q.pop_front();
            end
            exp_q.push_back(expected_rgb(s1_char, s1_scr1, s1_scr2, s1_obj, s1_en,
                                         lvbl, lhbl, pause));
            valid_q.push_back(s1_valid);
            s1_char  = char_pxl;
            s1_scr1  = scr1_pxl;
            s1_scr2  = scr2_pxl;
            s1_obj   = obj_pxl;
            s1_en    = gfx_en;
            s1_valid = checking;
            @(negedge clk);
            if (have_pend && pend_valid) begin
                check_count++;
                check_rgb("rgb", pend_exp, {red, green, blue});
            end
        end
    end

    task automatic wait_cen();
        do @(posedge clk); while (!cen);
    endtask

    task automatic align_phase(input logic [1:0] phase);
        do @(posedge clk); while (cen_cnt != phase);
    endtask

    // strobe, then busy must follow the grant rule within two clk
    task automatic palette_write(input host_addr_t a, input rgb_t d);
        bit granted;
        bit done;
        int n;
        @(posedge clk);
        host_we     <= 1'b1;
        host_target <= 1'b0;
        host_addr   <= a;
        host_data   <= d;
        @(posedge clk);  // strobe taken here
        host_we <= 1'b0;
        granted = 0;
        done    = 0;
        for (n = 0; n < 3 && !done; n++) begin
            @(posedge clk);
            check_busy("host_busy", !granted, host_busy);
            if (granted) begin
                done = 1;
            end else if (!cen) begin
                granted = 1;  // write lands on this edge
            end
        end
        if (!done) begin
            err_count++;
            $display("palette write to %h did not finish within two clk", a);
        end
        pal_model[a] = d;
    endtask

    task automatic prio_write(input logic [`PRIO_AW-1:0] a, input prio_sel_t d);
        @(posedge clk);
        host_we     <= 1'b1;
        host_target <= 1'b1;
        host_addr   <= host_addr_t'(a);
        host_data   <= rgb_t'(d);
        prio_model[a] = d;
    endtask

    task automatic load_table(input bit fixed, input logic [1:0] layer, input logic [1:0] hi);
        int n;
        for (n = 0; n < 2**`PRIO_AW; n++) begin
            if (fixed) begin
                prio_write(n[`PRIO_AW-1:0], {hi, layer});
            end else begin
                prio_write(n[`PRIO_AW-1:0], prio_sel_t'($urandom_range(15)));
            end
        end
        @(posedge clk);
        host_we <= 1'b0;
    endtask

    function automatic logic [3:0] rand_code();
        if ($urandom_range(3) == 0) begin
            return 4'hf;  // one in four transparent
        end
        return 4'($urandom_range(15));
    endfunction

    task automatic random_pixels(input int count, input bit rand_en, input bit rand_blank,
                                 input bit rand_pause);
        int         n;
        logic [1:0] s1_hi;
        logic [1:0] s2_hi;
        logic [3:0] o_hi;
        for (n = 0; n < count; n++) begin
            s1_hi = 2'($urandom_range(3));
            s2_hi = 2'($urandom_range(3));
            o_hi  = 4'($urandom_range(15));
            wait_cen();
            char_pxl <= rand_code();
            scr1_pxl <= {s1_hi, rand_code()};
            scr2_pxl <= {s2_hi, rand_code()};
            obj_pxl  <= {o_hi, rand_code()};
            gfx_en   <= rand_en ? 4'($urandom_range(15)) : 4'hf;
            lvbl     <= rand_blank ? 1'($urandom_range(1)) : 1'b1;
            lhbl     <= rand_blank ? 1'($urandom_range(1)) : 1'b1;
            pause    <= rand_pause ? 1'($urandom_range(1)) : 1'b0;
        end
    endtask

    task automatic start_checks();
        @(posedge clk);
        checking <= 1'b1;
    endtask

    // stop sampling and let the last pixels leave the pipeline
    task automatic drain_checks();
        @(posedge clk);
        checking <= 1'b0;
        repeat (3) wait_cen();
        @(negedge clk);
    endtask

    // table points at the objects so any entry can be reached, pause picks the bank
    task automatic readback(input host_addr_t a);
        load_table(1'b1, 2'd2, a[7:6]);
        @(posedge clk);
        lvbl  <= 1'b1;
        lhbl  <= 1'b1;
        pause <= a[8];
        start_checks();
        repeat (3) begin
            wait_cen();
            obj_pxl <= {2'($urandom_range(3)), a[5:0]};
            gfx_en  <= 4'($urandom_range(15));
        end
        drain_checks();
    endtask

    task automatic report_test(input string name);
        test_count++;
        if (err_count == errs_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            test_fails++;
            $display("test %0d %s: fail, %0d errors", test_count, name,
                     err_count - errs_before);
        end
        errs_before = err_count;
    endtask

    initial begin
        seed_val    = $urandom(32'h599d4d9c);
        clk         = 1'b0;
        reset       = 1'b1;
        cen         = 1'b0;
        cen_cnt     = 2'd0;
        char_pxl    = '0;
        scr1_pxl    = '0;
        scr2_pxl    = '0;
        obj_pxl     = '0;
        gfx_en      = 4'hf;
        lvbl        = 1'b0;  // blanked until the tables are loaded
        lhbl        = 1'b0;
        pause       = 1'b0;
        host_we     = 1'b0;
        host_target = 1'b0;
        host_addr   = '0;
        host_data   = '0;
        checking    = 1'b0;
        cycle_count = 0;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        test_fails  = 0;
        errs_before = 0;
        s1_valid    = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // outputs as reset left them
        @(negedge clk);
        check_rgb("rgb", '0, {red, green, blue});
        check_busy("host_busy", 1'b0, host_busy);
        report_test("reset");

        for (i = 0; i < 2**`PAL_AW; i++) begin
            palette_write(host_addr_t'(i), rgb_t'($urandom_range(4095)));
        end
        report_test("palette load");

        for (i = 0; i < 4; i++) begin
            load_table(1'b1, 2'(i), 2'($urandom_range(3)));
            start_checks();
            random_pixels(32, 1'b0, 1'b0, 1'b0);
            drain_checks();
        end
        report_test("palette path per layer");

        load_table(1'b0, 2'd0, 2'd0);
        start_checks();
        random_pixels(N_PIXELS, 1'b0, 1'b0, 1'b0);
        drain_checks();
        report_test("priority");

        start_checks();
        random_pixels(N_PIXELS, 1'b1, 1'b0, 1'b0);
        drain_checks();
        report_test("layer disable");

        start_checks();
        random_pixels(N_PIXELS, 1'b0, 1'b1, 1'b0);
        drain_checks();
        report_test("blanking");

        start_checks();
        random_pixels(N_PIXELS, 1'b1, 1'b0, 1'b1);
        drain_checks();
        report_test("pause palette");

        for (i = 0; i < N_WRITES; i++) begin
            wr_addr = host_addr_t'($urandom_range(2**`PAL_AW - 1));
            wr_data = rgb_t'($urandom_range(4095));
            align_phase(2'(i % 4));
            palette_write(wr_addr, wr_data);
            readback(wr_addr);
        end
        report_test("write arbitration");

        if (check_count == 0) begin
            err_count++;
            $display("no pixel reached the output compare");
        end
        $display("tests %0d, failed %0d, pixel checks %0d, errors %0d",
                 test_count, test_fails, check_count, err_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== pixel_mixer.f ====
+incdir+logic
logic/mixer_pkg.sv
logic/palette_bus_if.sv
logic/layer_priority.sv
logic/palette_writer.sv
logic/palette_store.sv
logic/pixel_mixer.sv
bench/mixer_tb.sv
